// File: all.f
hw/iommu_ptw_pkg.sv
hw/msi_addr_match.sv
hw/pte_check.sv
hw/ptw_walk_fsm.sv
hw/iommu_ptw_top.sv
tb/tb_clk_gen.sv
tb/tb_iommu_ptw.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_iommu_ptw \
    -f all.f --Mdir obj_dir -o tb_iommu_ptw
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_iommu_ptw > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
echo "Pass line missing from $LOG"
exit 1

// File: tb/tb_iommu_ptw.sv
// Directed tests only; memory model serves one read at a time and returns zero for unmapped words
`timescale 1ns/1ps

module tb_iommu_ptw;
    import iommu_ptw_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int TIMEOUT_CYCLES = 400 * NUM_TESTS;

    // Table pages of the stage-1 walks and the MSI table
    localparam logic [PPN_W-1:0]  ROOT_PPN   = 44'h100;
    localparam logic [PPN_W-1:0]  L2_PPN     = 44'h200;
    localparam logic [PPN_W-1:0]  L3_PPN     = 44'h300;
    localparam logic [PPN_W-1:0]  MSIPTP_PPN = 44'h800;
    // Walk IOVA, also inside the MSI pattern so stage 1 has to win
    localparam logic [IOVA_W-1:0] IOVA_A     = 39'h03_A007_5000;

    logic               clk;
    logic               rst_n;
    logic               iotlb_access;
    logic               iotlb_hit;
    ptw_req_t           req;
    ptw_cfg_t           cfg;
    ptw_mem_rsp_t       mem_rsp;
    ptw_mem_req_t       mem_req;
    logic               upd;
    iotlb_update_t      upd_data;
    logic               err;
    logic [CAUSE_W-1:0] cause;
    logic               bare;
    logic               active;

    // Sparse page table storage keyed by byte address
    logic [PTE_W-1:0] mem [logic [PLEN-1:0]];
    logic             slow_grant;
    logic [PLEN-1:0]  last_addr;
    int               req_count = 0;
    int               stall_cycles = 0;
    int               checks = 0;
    int               errors = 0;
    int               cycles = 0;
    integer           seed;

    tb_clk_gen u_clk (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    iommu_ptw_top uut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .iotlb_access_i (iotlb_access),
        .iotlb_hit_i    (iotlb_hit),
        .req_i          (req),
        .cfg_i          (cfg),
        .mem_rsp_i      (mem_rsp),
        .mem_req_o      (mem_req),
        .update_o       (upd),
        .update_data_o  (upd_data),
        .error_o        (err),
        .cause_o        (cause),
        .bare_o         (bare),
        .active_o       (active)
    );

    task automatic check_update(input string name, input iotlb_update_t got,
                                input iotlb_update_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input logic [CAUSE_W-1:0] got,
                               input logic [CAUSE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [PLEN-1:0] got,
                              input logic [PLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Grant after 0 to 3 cycles (3 when slowed), rvalid 1 to 3 cycles after grant
    initial begin : mem_model
        logic [PLEN-1:0] addr;
        int              dly;
        seed      = 11000;
        mem_rsp   = '0;
        last_addr = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req.req) begin
                addr      = mem_req.addr;
                last_addr = addr;
                req_count++;
                if (slow_grant) begin
                    dly = 3;
                end else begin
                    dly = {$random(seed)} % 4;
                end
                // Request must hold while the grant is pending
                repeat (dly) begin
                    @(posedge clk);
                    #1;
                    stall_cycles++;
                    check_bit("mem_req_o.req", mem_req.req, 1'b1);
                    check_addr("mem_req_o.addr", mem_req.addr, addr);
                end
                mem_rsp.gnt = 1'b1;
                @(posedge clk);
                #1;
                mem_rsp.gnt = 1'b0;
                dly = {$random(seed)} % 3;
                repeat (dly) begin
                    @(posedge clk);
                    #1;
                end
                mem_rsp.rvalid = 1'b1;
                mem_rsp.rdata  = mem.exists(addr) ? mem[addr] : '0;
                @(posedge clk);
                #1;
                mem_rsp.rvalid = 1'b0;
            end
        end
    end

    function automatic ptw_req_t make_req(input logic [IOVA_W-1:0] iova,
                                          input logic [PSCID_W-1:0] pscid, input logic st);
        ptw_req_t r;
        r.iova     = iova;
        r.pscid    = pscid;
        r.is_store = st;
        return r;
    endfunction

    function automatic ptw_cfg_t stage1_cfg();
        ptw_cfg_t c;
        c = '0;
        c.en_stage1  = 1'b1;
        c.iosatp_ppn = ROOT_PPN;
        // MSI fields set too, stage 1 must take priority
        c.msi_en      = 1'b1;
        c.msiptp_ppn  = MSIPTP_PPN;
        c.msi_mask    = 27'h0F00F0;
        c.msi_pattern = 27'h300005;
        return c;
    endfunction

    function automatic ptw_cfg_t msi_cfg();
        ptw_cfg_t c;
        c = stage1_cfg();
        c.en_stage1 = 1'b0;
        return c;
    endfunction

    // Pointer entry, only V and optionally G
    function automatic sv39_pte_t ptr_pte(input logic [PPN_W-1:0] ppn, input logic g);
        sv39_pte_t p;
        p     = '0;
        p.ppn = ppn;
        p.g   = g;
        p.v   = 1'b1;
        return p;
    endfunction

    // Readable, writable user leaf with A and D already set
    function automatic sv39_pte_t leaf_pte(input logic [PPN_W-1:0] ppn);
        sv39_pte_t p;
        p     = '0;
        p.ppn = ppn;
        p.d   = 1'b1;
        p.a   = 1'b1;
        p.u   = 1'b1;
        p.w   = 1'b1;
        p.r   = 1'b1;
        p.v   = 1'b1;
        return p;
    endfunction

    function automatic logic [PLEN-1:0] slot_addr(input logic [PPN_W-1:0] ppn,
                                                  input logic [8:0] idx);
        return {ppn, idx, 3'b000};
    endfunction

    // Level 1 maps 1G, 2 maps 2M, anything else 4K
    function automatic iotlb_update_t leaf_record(input ptw_req_t r, input int lvl,
                                                  input logic [PTE_W-1:0] content);
        iotlb_update_t u;
        u         = '0;
        u.vpn     = r.iova[38:12];
        u.pscid   = r.pscid;
        u.is_1g   = (lvl == 1);
        u.is_2m   = (lvl == 2);
        u.content = content;
        return u;
    endfunction

    // Fresh tables with the given entry at the leaf level
    task automatic place_tables(input logic [IOVA_W-1:0] iova, input int lvl,
                                input logic root_g, input sv39_pte_t leaf);
        mem.delete();
        if (lvl == 1) begin
            mem[slot_addr(ROOT_PPN, iova[38:30])] = leaf;
        end else begin
            mem[slot_addr(ROOT_PPN, iova[38:30])] = ptr_pte(L2_PPN, root_g);
            if (lvl == 2) begin
                mem[slot_addr(L2_PPN, iova[29:21])] = leaf;
            end else begin
                mem[slot_addr(L2_PPN, iova[29:21])] = ptr_pte(L3_PPN, 1'b0);
                mem[slot_addr(L3_PPN, iova[20:12])] = leaf;
            end
        end
    endtask

    task automatic issue_miss(input ptw_req_t r, input logic hit, output logic bare_seen);
        @(posedge clk);
        #1;
        req          = r;
        iotlb_hit    = hit;
        iotlb_access = 1'b1;
        @(negedge clk);
        bare_seen = bare;
        @(posedge clk);
        #1;
        iotlb_access = 1'b0;
        iotlb_hit    = 1'b0;
        // Walker has to use its captured copy from now on
        req = '0;
    endtask

    task automatic wait_end(output logic got_upd, output logic got_err,
                            output iotlb_update_t data, output logic [CAUSE_W-1:0] cz);
        logic done;
        done    = 1'b0;
        got_upd = 1'b0;
        got_err = 1'b0;
        data    = '0;
        cz      = '0;
        while (!done) begin
            @(negedge clk);
            if (upd || err) begin
                done    = 1'b1;
                got_upd = upd;
                got_err = err;
                data    = upd_data;
                cz      = cause;
                check_bit("active_o", active, 1'b1);
            end
        end
        // End pulses last one cycle, then idle
        @(negedge clk);
        check_bit("update_o", upd, 1'b0);
        check_bit("error_o", err, 1'b0);
        @(negedge clk);
        check_bit("active_o", active, 1'b0);
    endtask

    task automatic run_walk(input ptw_req_t r, input logic want_upd,
                            input iotlb_update_t exp_data, input logic [CAUSE_W-1:0] exp_cause);
        logic               b;
        logic               got_upd;
        logic               got_err;
        iotlb_update_t      data;
        logic [CAUSE_W-1:0] cz;
        issue_miss(r, 1'b0, b);
        check_bit("bare_o", b, 1'b0);
        wait_end(got_upd, got_err, data, cz);
        check_bit("update_o", got_upd, want_upd);
        check_bit("error_o", got_err, !want_upd);
        if (want_upd) begin
            check_update("update_data_o", data, exp_data);
        end else begin
            check_cause("cause_o", cz, exp_cause);
        end
    endtask

    task automatic expect_fault(input ptw_req_t r, input int lvl, input sv39_pte_t p,
                                input logic [CAUSE_W-1:0] exp_cause);
        place_tables(r.iova, lvl, 1'b0, p);
        run_walk(r, 1'b0, '0, exp_cause);
    endtask

    task automatic test_walk_4k;
        ptw_req_t  r;
        sv39_pte_t leaf;
        sv39_pte_t leaf_g;
        cfg  = stage1_cfg();
        r    = make_req(IOVA_A, 20'hABCDE, 1'b0);
        leaf = leaf_pte(44'h12345678A);
        place_tables(r.iova, 3, 1'b0, leaf);
        run_walk(r, 1'b1, leaf_record(r, 3, leaf), '0);
        // G on the root pointer carries into the leaf
        place_tables(r.iova, 3, 1'b1, leaf);
        leaf_g   = leaf;
        leaf_g.g = 1'b1;
        run_walk(r, 1'b1, leaf_record(r, 3, leaf_g), '0);
    endtask

    task automatic test_superpages;
        ptw_req_t  r;
        sv39_pte_t leaf;
        cfg  = stage1_cfg();
        // 2M leaf, low 9 PPN bits clear
        r    = make_req(IOVA_A, 20'h13579, 1'b1);
        leaf = leaf_pte(44'hA00);
        place_tables(r.iova, 2, 1'b0, leaf);
        run_walk(r, 1'b1, leaf_record(r, 2, leaf), '0);
        // 1G leaf, low 18 PPN bits clear
        r    = make_req(IOVA_A, 20'h2468A, 1'b0);
        leaf = leaf_pte(44'hC0000);
        place_tables(r.iova, 1, 1'b0, leaf);
        run_walk(r, 1'b1, leaf_record(r, 1, leaf), '0);
    endtask

    task automatic test_page_faults;
        ptw_req_t  ld;
        ptw_req_t  st;
        sv39_pte_t p;
        cfg = stage1_cfg();
        ld  = make_req(IOVA_A, 20'h00011, 1'b0);
        st  = make_req(IOVA_A, 20'h00022, 1'b1);
        p   = leaf_pte(44'h5000);
        p.v = 1'b0;
        expect_fault(ld, 3, p, CAUSE_LD_PAGE_FAULT);
        // 1G leaf with a low PPN bit set
        expect_fault(st, 1, leaf_pte(44'h40001), CAUSE_ST_PAGE_FAULT);
        p   = leaf_pte(44'h5000);
        p.a = 1'b0;
        expect_fault(ld, 3, p, CAUSE_LD_PAGE_FAULT);
        p   = leaf_pte(44'h5000);
        p.d = 1'b0;
        expect_fault(st, 3, p, CAUSE_ST_PAGE_FAULT);
        // Pointer found where no lower level exists
        expect_fault(ld, 3, ptr_pte(44'h5000, 1'b0), CAUSE_LD_PAGE_FAULT);
        p          = leaf_pte(44'h5000);
        p.reserved = 10'h200;
        expect_fault(st, 3, p, CAUSE_ST_PAGE_FAULT);
    endtask

    task automatic test_msi;
        ptw_req_t        r;
        msi_pte_t        mpte;
        msi_pte_t        bad;
        iotlb_update_t   exp;
        logic [PLEN-1:0] msi_addr;
        int              n;
        cfg = msi_cfg();
        // Outside the mask the VPN equals the pattern, bits 19:16 = C and 7:4 = 9
        r = make_req({27'h3C0095, 12'h000}, 20'h00777, 1'b1);
        // Masked bits packed lowest first give file index C9
        msi_addr = {MSIPTP_PPN, 12'h000} | {44'h0, 8'hC9, 4'h0};
        mpte     = '0;
        mpte.v   = 1'b1;
        mpte.m   = MSI_MODE_WT;
        mpte.ppn = 44'hABCDE;
        mem.delete();
        mem[msi_addr] = mpte;
        n   = req_count;
        exp = leaf_record(r, 3, mpte);
        exp.is_msi = 1'b1;
        run_walk(r, 1'b1, exp, '0);
        check_addr("mem_req_o.addr", last_addr, msi_addr);
        check_bit("single MSI read", (req_count == n + 1), 1'b1);
        bad   = mpte;
        bad.v = 1'b0;
        mem[msi_addr] = bad;
        run_walk(r, 1'b0, '0, CAUSE_MSI_INVALID);
        bad   = mpte;
        bad.m = 2'd2;
        mem[msi_addr] = bad;
        run_walk(r, 1'b0, '0, CAUSE_TRANS_DISALLOWED);
        // Mode check overrides an invalid entry
        bad   = mpte;
        bad.v = 1'b0;
        bad.m = 2'd2;
        mem[msi_addr] = bad;
        run_walk(r, 1'b0, '0, CAUSE_TRANS_DISALLOWED);
        bad            = mpte;
        bad.reserved_1 = 7'h10;
        mem[msi_addr]  = bad;
        run_walk(r, 1'b0, '0, CAUSE_MSI_MISCONF);
    endtask

    task automatic test_bare_and_hit;
        ptw_req_t r;
        logic     b;
        int       n;
        cfg = msi_cfg();
        // Bit 21 differs from the pattern outside the mask
        r = make_req({27'h1C0095, 12'h000}, 20'h00333, 1'b0);
        n = req_count;
        issue_miss(r, 1'b0, b);
        check_bit("bare_o", b, 1'b1);
        repeat (4) @(negedge clk);
        check_bit("active_o", active, 1'b0);
        check_bit("mem_req_o.req", (req_count != n), 1'b0);
        // Hit on a stage-1 context starts nothing
        cfg = stage1_cfg();
        issue_miss(make_req(IOVA_A, 20'h00333, 1'b0), 1'b1, b);
        check_bit("bare_o", b, 1'b0);
        repeat (4) @(negedge clk);
        check_bit("active_o", active, 1'b0);
        check_bit("mem_req_o.req", (req_count != n), 1'b0);
    endtask

    task automatic test_back_pressure;
        ptw_req_t  r;
        sv39_pte_t leaf;
        int        stalls;
        cfg  = stage1_cfg();
        r    = make_req(IOVA_A, 20'hABCDE, 1'b0);
        leaf = leaf_pte(44'h12345678A);
        place_tables(r.iova, 3, 1'b0, leaf);
        stalls     = stall_cycles;
        slow_grant = 1'b1;
        run_walk(r, 1'b1, leaf_record(r, 3, leaf), '0);
        slow_grant = 1'b0;
        // Three reads, each held three cycles
        check_bit("grant stalls seen", (stall_cycles == stalls + 9), 1'b1);
    endtask

    initial begin : watchdog
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the walker never finished", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin : main
        iotlb_access = 1'b0;
        iotlb_hit    = 1'b0;
        req          = '0;
        cfg          = '0;
        slow_grant   = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        // Quiet outputs out of reset
        check_bit("mem_req_o.req", mem_req.req, 1'b0);
        check_bit("update_o", upd, 1'b0);
        check_bit("error_o", err, 1'b0);
        check_bit("bare_o", bare, 1'b0);
        check_bit("active_o", active, 1'b0);
        test_walk_4k();
        test_superpages();
        test_page_faults();
        test_msi();
        test_bare_and_hit();
        test_back_pressure();
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: tb/tb_clk_gen.sv
// Free-running 10 ns clock; active-low reset held for the first 8 rising edges
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    // 100 MHz clock
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Release just after an edge so no flop sees it mid-cycle
    initial begin
        rst_no = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

// File: hw/iommu_ptw_top.sv
// Single-stage Sv39 walker with MSI write-through; req_i is captured on the miss cycle only
`timescale 1ns/1ps

module iommu_ptw_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              iotlb_access_i,
    input  logic                              iotlb_hit_i,
    input  iommu_ptw_pkg::ptw_req_t           req_i,
    input  iommu_ptw_pkg::ptw_cfg_t           cfg_i,
    input  iommu_ptw_pkg::ptw_mem_rsp_t       mem_rsp_i,
    output iommu_ptw_pkg::ptw_mem_req_t       mem_req_o,
    output logic                              update_o,
    output iommu_ptw_pkg::iotlb_update_t      update_data_o,
    output logic                              error_o,
    output logic [iommu_ptw_pkg::CAUSE_W-1:0] cause_o,
    output logic                              bare_o,
    output logic                              active_o
);
    import iommu_ptw_pkg::*;

    logic            miss;
    logic            is_imsic;
    logic [PLEN-1:0] msi_pte_addr;
    pt_word_u        word;
    pt_lvl_e         lvl;
    logic            is_msi;
    logic            is_store;
    pte_verdict_t    verdict;

    // IOTLB lookup that missed
    assign miss = iotlb_access_i & ~iotlb_hit_i;

    // Match runs on the live request, used only in the miss cycle
    msi_addr_match u_msi_match (
        .vpn_i          (req_i.iova[IOVA_W-1:12]),
        .cfg_i          (cfg_i),
        .is_imsic_o     (is_imsic),
        .msi_pte_addr_o (msi_pte_addr)
    );

    pte_check u_pte_check (
        .word_i     (word),
        .lvl_i      (lvl),
        .is_msi_i   (is_msi),
        .is_store_i (is_store),
        .verdict_o  (verdict)
    );

    ptw_walk_fsm u_walk (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .miss_i         (miss),
        .req_i          (req_i),
        .cfg_i          (cfg_i),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .is_imsic_i     (is_imsic),
        .msi_pte_addr_i (msi_pte_addr),
        .word_o         (word),
        .lvl_o          (lvl),
        .is_msi_o       (is_msi),
        .is_store_o     (is_store),
        .verdict_i      (verdict),
        .update_o       (update_o),
        .update_data_o  (update_data_o),
        .error_o        (error_o),
        .cause_o        (cause_o),
        .bare_o         (bare_o),
        .active_o       (active_o)
    );

endmodule

// File: hw/ptw_walk_fsm.sv
// One walk at a time, misses while busy are dropped; cfg_i must stay stable during a walk
`timescale 1ns/1ps

module ptw_walk_fsm (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              miss_i,
    input  iommu_ptw_pkg::ptw_req_t           req_i,
    input  iommu_ptw_pkg::ptw_cfg_t           cfg_i,
    output iommu_ptw_pkg::ptw_mem_req_t       mem_req_o,
    input  iommu_ptw_pkg::ptw_mem_rsp_t       mem_rsp_i,
    input  logic                              is_imsic_i,
    input  logic [iommu_ptw_pkg::PLEN-1:0]    msi_pte_addr_i,
    output iommu_ptw_pkg::pt_word_u           word_o,
    output iommu_ptw_pkg::pt_lvl_e            lvl_o,
    output logic                              is_msi_o,
    output logic                              is_store_o,
    input  iommu_ptw_pkg::pte_verdict_t       verdict_i,
    output logic                              update_o,
    output iommu_ptw_pkg::iotlb_update_t      update_data_o,
    output logic                              error_o,
    output logic [iommu_ptw_pkg::CAUSE_W-1:0] cause_o,
    output logic                              bare_o,
    output logic                              active_o
);
    import iommu_ptw_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        PROPAGATE_ERROR
    } state_e;

    state_e             state_q, state_n;
    pt_lvl_e            lvl_q, lvl_n;
    logic [PLEN-1:0]    pptr_q, pptr_n;
    ptw_req_t           req_q, req_n;
    logic               msi_q, msi_n;
    logic               global_q, global_n;
    logic [CAUSE_W-1:0] cause_q, cause_n;
    // Response is acted on one cycle after arrival
    logic               rvalid_q;
    pt_word_u           word_q;
    sv39_pte_t          leaf_pte;

    // Checker sees the registered word and current walk context
    assign word_o     = word_q;
    assign lvl_o      = lvl_q;
    assign is_msi_o   = msi_q;
    assign is_store_o = req_q.is_store;
    assign active_o   = (state_q != IDLE);

    always_comb begin : walk
        state_n  = state_q;
        lvl_n    = lvl_q;
        pptr_n   = pptr_q;
        req_n    = req_q;
        msi_n    = msi_q;
        global_n = global_q;
        cause_n  = cause_q;
        mem_req_o.req  = 1'b0;
        mem_req_o.addr = pptr_q;
        update_o = 1'b0;
        error_o  = 1'b0;
        cause_o  = '0;
        bare_o   = 1'b0;

        case (state_q)
            IDLE: begin
                if (miss_i) begin
                    // Every walk starts from the root level
                    req_n    = req_i;
                    lvl_n    = LVL1;
                    global_n = 1'b0;
                    msi_n    = 1'b0;
                    if (cfg_i.en_stage1) begin
                        // Root entry indexed by VPN[2]
                        pptr_n  = {cfg_i.iosatp_ppn, req_i.iova[38:30], 3'b0};
                        state_n = WAIT_GRANT;
                    end else if (is_imsic_i) begin
                        // Single MSI table read
                        pptr_n  = msi_pte_addr_i;
                        msi_n   = 1'b1;
                        state_n = WAIT_GRANT;
                    end else begin
                        // Nothing to translate, stay idle
                        bare_o = 1'b1;
                    end
                end
            end

            WAIT_GRANT: begin
                mem_req_o.req = 1'b1;
                if (mem_rsp_i.gnt) begin
                    state_n = PTE_LOOKUP;
                end
            end

            PTE_LOOKUP: begin
                if (rvalid_q) begin
                    if (verdict_i.fault) begin
                        // Error goes out on the following cycle
                        cause_n = verdict_i.cause;
                        state_n = PROPAGATE_ERROR;
                    end else if (msi_q || verdict_i.leaf) begin
                        update_o = 1'b1;
                        state_n  = IDLE;
                    end else begin
                        // Pointer entry, descend one level
                        global_n = global_q | word_q.sv39.g;
                        state_n  = WAIT_GRANT;
                        if (lvl_q == LVL1) begin
                            lvl_n  = LVL2;
                            pptr_n = {word_q.sv39.ppn, req_q.iova[29:21], 3'b0};
                        end else begin
                            lvl_n  = LVL3;
                            pptr_n = {word_q.sv39.ppn, req_q.iova[20:12], 3'b0};
                        end
                    end
                end
            end

            PROPAGATE_ERROR: begin
                error_o = 1'b1;
                cause_o = cause_q;
                state_n = IDLE;
            end

            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_comb begin : update_rec
        // G from any pointer on the way applies to the leaf
        leaf_pte   = word_q.sv39;
        leaf_pte.g = leaf_pte.g | global_q;
        update_data_o.vpn    = req_q.iova[IOVA_W-1:12];
        update_data_o.pscid  = req_q.pscid;
        update_data_o.is_msi = msi_q;
        // Size flags from the level where the leaf was found
        update_data_o.is_1g  = !msi_q && (lvl_q == LVL1);
        update_data_o.is_2m  = !msi_q && (lvl_q == LVL2);
        if (msi_q) begin
            update_data_o.content = word_q;
        end else begin
            update_data_o.content = leaf_pte;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            state_q  <= IDLE;
            lvl_q    <= LVL1;
            msi_q    <= 1'b0;
            global_q <= 1'b0;
            cause_q  <= '0;
            rvalid_q <= 1'b0;
        end else begin
            state_q  <= state_n;
            lvl_q    <= lvl_n;
            msi_q    <= msi_n;
            global_q <= global_n;
            cause_q  <= cause_n;
            rvalid_q <= mem_rsp_i.rvalid;
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        pptr_q <= pptr_n;
        req_q  <= req_n;
        // Keep the last returned word
        if (mem_rsp_i.rvalid) begin
            word_q <= mem_rsp_i.rdata;
        end
    end

    // Request and address stay put until the memory grants
    a_req_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.req && !mem_rsp_i.gnt |=> mem_req_o.req && $stable(mem_req_o.addr));

    // A walk ends in either an update or an error, never both
    a_end_excl : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_o && error_o));

endmodule

// File: hw/pte_check.sv
// Pure combinational check of one fetched word; cause is zero whenever fault is low
`timescale 1ns/1ps

module pte_check (
    input  iommu_ptw_pkg::pt_word_u     word_i,
    input  iommu_ptw_pkg::pt_lvl_e      lvl_i,
    input  logic                        is_msi_i,
    input  logic                        is_store_i,
    output iommu_ptw_pkg::pte_verdict_t verdict_o
);
    import iommu_ptw_pkg::*;

    sv39_pte_t pte;
    msi_pte_t  mpte;
    logic      is_leaf;
    logic      pf;

    // Same word, two readings
    assign pte  = word_i.sv39;
    assign mpte = word_i.msi;

    // R or X marks a leaf
    assign is_leaf = pte.r | pte.x;

    always_comb begin : sv39_rules
        // Invalid entry, W without R, or reserved bits in use
        pf = !pte.v || (pte.w && !pte.r) || (|pte.reserved);
        if (is_leaf) begin
            // Superpage must be aligned to its own size
            if (lvl_i == LVL1 && pte.ppn[17:0] != '0) pf = 1'b1;
            if (lvl_i == LVL2 && pte.ppn[8:0] != '0) pf = 1'b1;
            // No hardware A/D update, software must have set them
            if (!pte.a || !pte.r || (is_store_i && !pte.d)) pf = 1'b1;
        end else begin
            // D, A and U are reserved on pointers
            if (pte.a || pte.d || pte.u) pf = 1'b1;
            // No level left below L3
            if (lvl_i == LVL3) pf = 1'b1;
        end
    end

    always_comb begin : verdict
        verdict_o = '0;
        if (is_msi_i) begin
            // MSI walk always ends on this word
            verdict_o.leaf = 1'b1;
            // Later checks override earlier ones
            if (!mpte.v || mpte.c) begin
                verdict_o.cause = CAUSE_MSI_INVALID;
            end
            if (mpte.m != MSI_MODE_WT) begin
                verdict_o.cause = CAUSE_TRANS_DISALLOWED;
            end
            if ((|mpte.reserved_1) || (|mpte.reserved_2)) begin
                verdict_o.cause = CAUSE_MSI_MISCONF;
            end
            verdict_o.fault = (verdict_o.cause != '0);
        end else begin
            verdict_o.leaf  = is_leaf;
            verdict_o.fault = pf;
            if (pf) begin
                // Page fault follows the original access type
                verdict_o.cause = is_store_i ? CAUSE_ST_PAGE_FAULT : CAUSE_LD_PAGE_FAULT;
            end
        end
    end

    // A fault must never reach the walker without a cause code
    always_comb begin : chk_cause
        if (verdict_o.fault) begin
            assert (verdict_o.cause != '0)
                else $error("pte_check fault raised with zero cause");
        end
    end

endmodule

// File: hw/msi_addr_match.sv
// Only the first IMSIC_NUM_W set bits of msi_mask feed the file index; match needs stage 1 off
`timescale 1ns/1ps

module msi_addr_match (
    input  logic [iommu_ptw_pkg::VPN_W-1:0] vpn_i,
    input  iommu_ptw_pkg::ptw_cfg_t         cfg_i,
    output logic                            is_imsic_o,
    output logic [iommu_ptw_pkg::PLEN-1:0]  msi_pte_addr_o
);
    import iommu_ptw_pkg::*;

    logic [IMSIC_NUM_W-1:0] imsic_num;
    logic [VPN_W-1:0]       diff;

    // Bits that differ from the pattern
    assign diff = vpn_i ^ cfg_i.msi_pattern;

    // Masked positions are don't-care for the match
    assign is_imsic_o = !cfg_i.en_stage1 && cfg_i.msi_en && ((diff & ~cfg_i.msi_mask) == '0);

    // Gather VPN bits under the mask, lowest first
    always_comb begin : extract_num
        int unsigned k;
        imsic_num = '0;
        k = 0;
        for (int i = 0; i < VPN_W; i++) begin
            if (cfg_i.msi_mask[i]) begin
                // Extra mask bits beyond the index width are dropped
                if (k < IMSIC_NUM_W) begin
                    imsic_num[k] = vpn_i[i];
                end
                k++;
            end
        end
    end

    // Table base from msiptp, 16-byte entries
    assign msi_pte_addr_o = {cfg_i.msiptp_ppn, 12'b0}
                          | {{(PLEN-IMSIC_NUM_W-4){1'b0}}, imsic_num, 4'b0};

endmodule

// File: hw/iommu_ptw_pkg.sv
// Sv39 single stage only; MSI entries follow the write-through layout, MRIF entries are not described
package iommu_ptw_pkg;

    // Address and field widths
    localparam int unsigned IOVA_W      = 39;
    localparam int unsigned VPN_W       = 27;
    localparam int unsigned PPN_W       = 44;
    localparam int unsigned PLEN        = 56;
    localparam int unsigned PSCID_W     = 20;
    localparam int unsigned CAUSE_W     = 12;
    localparam int unsigned IMSIC_NUM_W = 8;
    localparam int unsigned PTE_W       = 64;

    // Fault causes reported with error_o
    localparam logic [CAUSE_W-1:0] CAUSE_LD_PAGE_FAULT    = 12'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_ST_PAGE_FAULT    = 12'd15;
    localparam logic [CAUSE_W-1:0] CAUSE_TRANS_DISALLOWED = 12'd260;
    localparam logic [CAUSE_W-1:0] CAUSE_MSI_INVALID      = 12'd262;
    localparam logic [CAUSE_W-1:0] CAUSE_MSI_MISCONF      = 12'd263;

    // MSI entry mode field, write-through
    localparam logic [1:0] MSI_MODE_WT = 2'd3;

    // Walk level, LVL1 maps 1G, LVL2 maps 2M, LVL3 maps 4K
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } pt_lvl_e;

    // Sv39 entry, bits 63:54 reserved since Svnapot and Svpbmt are absent
    typedef struct packed {
        logic [9:0]       reserved;
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } sv39_pte_t;

    // MSI write-through entry, first doubleword only
    typedef struct packed {
        logic             c;
        logic [8:0]       reserved_2;
        logic [PPN_W-1:0] ppn;
        logic [6:0]       reserved_1;
        logic [1:0]       m;
        logic             v;
    } msi_pte_t;

    // One fetched word, read as Sv39 or MSI entry depending on walk kind
    typedef union packed {
        sv39_pte_t sv39;
        msi_pte_t  msi;
    } pt_word_u;

    // Translation request captured on a miss
    typedef struct packed {
        logic [IOVA_W-1:0]  iova;
        logic [PSCID_W-1:0] pscid;
        logic               is_store;
    } ptw_req_t;

    // Context configuration, stable for the length of a walk
    typedef struct packed {
        logic             en_stage1;
        logic [PPN_W-1:0] iosatp_ppn;
        logic             msi_en;
        logic [PPN_W-1:0] msiptp_ppn;
        logic [VPN_W-1:0] msi_mask;
        logic [VPN_W-1:0] msi_pattern;
    } ptw_cfg_t;

    // Read port, req held until gnt
    typedef struct packed {
        logic            req;
        logic [PLEN-1:0] addr;
    } ptw_mem_req_t;

    // Exactly one rvalid follows each grant
    typedef struct packed {
        logic             gnt;
        logic             rvalid;
        logic [PTE_W-1:0] rdata;
    } ptw_mem_rsp_t;

    // IOTLB fill record, meaningful while update_o is high
    typedef struct packed {
        logic [VPN_W-1:0]   vpn;
        logic [PSCID_W-1:0] pscid;
        logic               is_2m;
        logic               is_1g;
        logic               is_msi;
        logic [PTE_W-1:0]   content;
    } iotlb_update_t;

    // Entry checker result
    typedef struct packed {
        logic               fault;
        logic               leaf;
        logic [CAUSE_W-1:0] cause;
    } pte_verdict_t;

endpackage
